// ==== common/cp0Pkg.sv ====
// --------------------
// CP0 exception and register field types
// ExcFlags is ordered from highest to lowest priority
// --------------------
package cp0Pkg;

    typedef struct packed {
        logic interrupt;
        logic fetchAddrErr;
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic eret;
        logic trap;
        logic overflow;
        logic storeAddrErr;
        logic loadAddrErr;
        logic tlbRefill;
        logic tlbInvalid;
        logic tlbModified;
    } ExcFlags;

    typedef enum logic [3:0] {
        ExcNone,
        ExcInterrupt,
        ExcFetchAddrErr,
        ExcReservedInstr,
        ExcSyscall,
        ExcBreak,
        ExcEret,
        ExcTrap,
        ExcOverflow,
        ExcStoreAddrErr,
        ExcLoadAddrErr,
        ExcTlbRefill,
        ExcTlbInvalid,
        ExcTlbModified
    } ExcKind;

    typedef struct packed {
        logic [7:0] im;
        logic       exl;
        logic       ie;
    } StatusFields;

    typedef struct packed {
        logic       bd;
        logic       ti;
        logic [5:0] ip72;
        logic [1:0] ip10;
        logic [4:0] excCode;
    } CauseFields;

endpackage

// ==== common/cp0_params.svh ====
// --------------------
// CP0 register numbers, TLB sizing and reset values
// Register numbers follow the MIPS32 CP0 map, select 0 only
// --------------------
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

`define CP0_REG_INDEX     5'd0
`define CP0_REG_ENTRYLO0  5'd2
`define CP0_REG_ENTRYLO1  5'd3
`define CP0_REG_BADVADDR  5'd8
`define CP0_REG_COUNT     5'd9
`define CP0_REG_ENTRYHI   5'd10
`define CP0_REG_COMPARE   5'd11
`define CP0_REG_STATUS    5'd12
`define CP0_REG_CAUSE     5'd13
`define CP0_REG_EPC       5'd14

`define TLB_ENTRIES       16
`define TLB_IDX_W         4

// BEV=1 general exception entry
`define EXC_VECTOR        32'hBFC0_0380

`define COMPARE_RESET     32'hFFFF_FFFF

`endif

// ==== common/tlbPkg.sv ====
// --------------------
// TLB entry field types
// EntryLo layout matches the low 26 bits of the register
// --------------------
package tlbPkg;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
    } EntryHiFields;

    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } EntryLoFields;

    typedef struct packed {
        EntryHiFields hi;
        EntryLoFields lo0;
        EntryLoFields lo1;
    } TlbEntry;

endpackage

// ==== cp0/cp0Regs.sv ====
// --------------------
// CP0 register file with combinational read port
// Exceptions win over a same-cycle software write
// TLB results win over software writes to TLB registers
// Count advances every second cycle
// --------------------
`timescale 1ns/100ps
`include "cp0_params.svh"

module cp0Regs import cp0Pkg::*, tlbPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [5:0]            extInt,
    input  logic                  cp0Wr,
    input  logic [4:0]            cp0WrAddr,
    input  logic [31:0]           cp0WrData,
    input  logic [4:0]            cp0RdAddr,
    input  logic                  tlbpReq,
    input  logic                  tlbrReq,
    input  ExcKind                excKind,
    input  logic [31:0]           wbPc,
    input  logic                  wbInDelaySlot,
    input  logic [31:0]           wbBadAddr,
    input  logic                  probeHit,
    input  logic [`TLB_IDX_W-1:0] probeIdx,
    input  TlbEntry               tlbRdEntry,
    output logic [31:0]           cp0RdData,
    output logic [7:0]            statusIm,
    output logic                  statusIe,
    output logic                  statusExl,
    output logic [7:0]            causeIp,
    output logic [31:0]           epc,
    output logic [`TLB_IDX_W-1:0] cp0Index,
    output EntryHiFields          cp0EntryHi,
    output EntryLoFields          cp0EntryLo0,
    output EntryLoFields          cp0EntryLo1
);

    logic                  indexP;
    logic [`TLB_IDX_W-1:0] indexIdx;
    logic [31:0]           badVAddr;
    logic [31:0]           count;
    logic                  countHalf;
    logic [31:0]           compare;
    StatusFields           status;
    CauseFields            cause;
    logic [31:0]           epcReg;
    logic                  timerInt;
    logic                  excAny;
    logic                  excCapture;
    logic                  codeValid;
    logic [4:0]            excCode;

    logic wrIndex, wrLo0, wrLo1, wrHi, wrCount, wrCompare, wrStatus, wrCause, wrEpc;

    assign wrIndex   = cp0Wr && (cp0WrAddr == `CP0_REG_INDEX);
    assign wrLo0     = cp0Wr && (cp0WrAddr == `CP0_REG_ENTRYLO0);
    assign wrLo1     = cp0Wr && (cp0WrAddr == `CP0_REG_ENTRYLO1);
    assign wrHi      = cp0Wr && (cp0WrAddr == `CP0_REG_ENTRYHI);
    assign wrCount   = cp0Wr && (cp0WrAddr == `CP0_REG_COUNT);
    assign wrCompare = cp0Wr && (cp0WrAddr == `CP0_REG_COMPARE);
    assign wrStatus  = cp0Wr && (cp0WrAddr == `CP0_REG_STATUS);
    assign wrCause   = cp0Wr && (cp0WrAddr == `CP0_REG_CAUSE);
    assign wrEpc     = cp0Wr && (cp0WrAddr == `CP0_REG_EPC);

    assign excAny     = (excKind != ExcNone);
    // EPC and BD are frozen while already at exception level
    assign excCapture = excAny && (excKind != ExcEret) && !status.exl;
    assign timerInt   = (count == compare);

    always_comb begin
        codeValid = 1'b1;
        case (excKind)
            ExcInterrupt:     excCode = 5'h00;
            ExcTlbModified:   excCode = 5'h01;
            ExcTlbRefill:     excCode = 5'h02;
            ExcTlbInvalid:    excCode = 5'h02;
            ExcFetchAddrErr:  excCode = 5'h04;
            ExcLoadAddrErr:   excCode = 5'h04;
            ExcStoreAddrErr:  excCode = 5'h05;
            ExcSyscall:       excCode = 5'h08;
            ExcBreak:         excCode = 5'h09;
            ExcReservedInstr: excCode = 5'h0a;
            ExcOverflow:      excCode = 5'h0c;
            ExcTrap:          excCode = 5'h0d;
            default: begin
                excCode   = 5'h00;
                codeValid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            indexP   <= 1'b0;
            indexIdx <= '0;
        end else if (tlbpReq) begin
            indexP   <= ~probeHit;
            indexIdx <= probeIdx;
        end else if (wrIndex) begin
            indexIdx <= cp0WrData[`TLB_IDX_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cp0EntryHi  <= '0;
            cp0EntryLo0 <= '0;
            cp0EntryLo1 <= '0;
        end else if (tlbrReq) begin
            cp0EntryHi  <= tlbRdEntry.hi;
            cp0EntryLo0 <= tlbRdEntry.lo0;
            cp0EntryLo1 <= tlbRdEntry.lo1;
        end else begin
            if (wrHi) begin
                cp0EntryHi <= '{vpn2: cp0WrData[31:13], asid: cp0WrData[7:0]};
            end
            if (wrLo0) begin
                cp0EntryLo0 <= cp0WrData[25:0];
            end
            if (wrLo1) begin
                cp0EntryLo1 <= cp0WrData[25:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            badVAddr <= '0;
        end else if (excKind == ExcFetchAddrErr) begin
            badVAddr <= wbPc;
        end else if (excKind == ExcLoadAddrErr || excKind == ExcStoreAddrErr) begin
            badVAddr <= wbBadAddr;
        end
    end

    // Half-rate counter, a write restarts the phase
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count     <= '0;
            countHalf <= 1'b0;
            compare   <= `COMPARE_RESET;
        end else begin
            if (wrCount) begin
                count     <= cp0WrData;
                countHalf <= 1'b0;
            end else begin
                countHalf <= ~countHalf;
                if (countHalf) begin
                    count <= count + 32'd1;
                end
            end
            if (wrCompare) begin
                compare <= cp0WrData;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            status <= '0;
        end else begin
            if (wrStatus) begin
                status.im <= cp0WrData[15:8];
                status.ie <= cp0WrData[0];
            end
            if (excAny) begin
                status.exl <= (excKind != ExcEret);
            end else if (wrStatus) begin
                status.exl <= cp0WrData[1];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cause <= '0;
        end else begin
            // Timer line lands on IP7
            cause.ip72 <= extInt | {timerInt, 5'b0};
            if (wrCompare) begin
                cause.ti <= 1'b0;
            end else if (timerInt) begin
                cause.ti <= 1'b1;
            end
            if (wrCause) begin
                cause.ip10 <= cp0WrData[9:8];
            end
            if (excCapture) begin
                cause.bd <= wbInDelaySlot;
            end
            if (codeValid) begin
                cause.excCode <= excCode;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            epcReg <= '0;
        end else if (excCapture) begin
            epcReg <= wbInDelaySlot ? (wbPc - 32'd4) : wbPc;
        end else if (wrEpc) begin
            epcReg <= cp0WrData;
        end
    end

    always_comb begin
        case (cp0RdAddr)
            `CP0_REG_INDEX:    cp0RdData = {indexP, {(31 - `TLB_IDX_W){1'b0}}, indexIdx};
            `CP0_REG_ENTRYLO0: cp0RdData = {6'b0, cp0EntryLo0};
            `CP0_REG_ENTRYLO1: cp0RdData = {6'b0, cp0EntryLo1};
            `CP0_REG_BADVADDR: cp0RdData = badVAddr;
            `CP0_REG_COUNT:    cp0RdData = count;
            `CP0_REG_ENTRYHI:  cp0RdData = {cp0EntryHi.vpn2, 5'b0, cp0EntryHi.asid};
            `CP0_REG_COMPARE:  cp0RdData = compare;
            // BEV reads as 1
            `CP0_REG_STATUS:   cp0RdData = {9'b0, 1'b1, 6'b0, status.im, 6'b0,
                                            status.exl, status.ie};
            `CP0_REG_CAUSE:    cp0RdData = {cause.bd, cause.ti, 14'b0, cause.ip72,
                                            cause.ip10, 1'b0, cause.excCode, 2'b0};
            `CP0_REG_EPC:      cp0RdData = epcReg;
            default:           cp0RdData = 32'h0;
        endcase
    end

    assign statusIm  = status.im;
    assign statusIe  = status.ie;
    assign statusExl = status.exl;
    assign causeIp   = {cause.ip72, cause.ip10};
    assign epc       = epcReg;
    assign cp0Index  = indexIdx;

endmodule

// ==== cp0/excPriority.sv ====
// --------------------
// Exception prioritizer, purely combinational
// The interrupt flag in wbExc is ignored, the request is
// formed here from Cause.IP, Status.IM, IE and EXL
// --------------------
`timescale 1ns/100ps
`include "cp0_params.svh"

module excPriority import cp0Pkg::*; (
    input  ExcFlags      wbExc,
    input  logic [7:0]   statusIm,
    input  logic         statusIe,
    input  logic         statusExl,
    input  logic [7:0]   causeIp,
    input  logic [31:0]  epc,
    output ExcKind       excKind,
    output logic         excTaken,
    output logic [31:0]  excTarget
);

    logic intReq;

    // Pending and unmasked, only outside exception level
    assign intReq = (|(causeIp & statusIm)) && statusIe && !statusExl;

    always_comb begin
        if (intReq)                   excKind = ExcInterrupt;
        else if (wbExc.fetchAddrErr)  excKind = ExcFetchAddrErr;
        else if (wbExc.reservedInstr) excKind = ExcReservedInstr;
        else if (wbExc.syscall)       excKind = ExcSyscall;
        else if (wbExc.brk)           excKind = ExcBreak;
        else if (wbExc.eret)          excKind = ExcEret;
        else if (wbExc.trap)          excKind = ExcTrap;
        else if (wbExc.overflow)      excKind = ExcOverflow;
        else if (wbExc.storeAddrErr)  excKind = ExcStoreAddrErr;
        else if (wbExc.loadAddrErr)   excKind = ExcLoadAddrErr;
        else if (wbExc.tlbRefill)     excKind = ExcTlbRefill;
        else if (wbExc.tlbInvalid)    excKind = ExcTlbInvalid;
        else if (wbExc.tlbModified)   excKind = ExcTlbModified;
        else                          excKind = ExcNone;
    end

    // Eret also flushes, it just returns to EPC
    assign excTaken  = (excKind != ExcNone);
    assign excTarget = (excKind == ExcEret) ? epc : `EXC_VECTOR;

endmodule

// ==== design/cp0Top.sv ====
// --------------------
// CP0 with prioritizer and joint TLB
// TLB serves only TLBP, TLBR and TLBWI
// wbExc.interrupt is expected low
// --------------------
`timescale 1ns/100ps
`include "cp0_params.svh"

module cp0Top import cp0Pkg::*, tlbPkg::*; (
    input  logic         clk,
    input  logic         arstN,
    input  logic [5:0]   extInt,
    input  logic         cp0Wr,
    input  logic [4:0]   cp0WrAddr,
    input  logic [31:0]  cp0WrData,
    input  logic [4:0]   cp0RdAddr,
    input  logic         tlbpReq,
    input  logic         tlbrReq,
    input  logic         tlbwiReq,
    input  ExcFlags      wbExc,
    input  logic [31:0]  wbPc,
    input  logic         wbInDelaySlot,
    input  logic [31:0]  wbBadAddr,
    output logic [31:0]  cp0RdData,
    output logic         excTaken,
    output logic [31:0]  excTarget
);

    ExcKind                excKind;
    logic [7:0]            statusIm;
    logic                  statusIe;
    logic                  statusExl;
    logic [7:0]            causeIp;
    logic [31:0]           epc;
    logic [`TLB_IDX_W-1:0] cp0Index;
    EntryHiFields          cp0EntryHi;
    EntryLoFields          cp0EntryLo0;
    EntryLoFields          cp0EntryLo1;
    TlbEntry               wrEntry;
    TlbEntry               tlbRdEntry;
    logic                  probeHit;
    logic [`TLB_IDX_W-1:0] probeIdx;

    assign wrEntry = '{hi: cp0EntryHi, lo0: cp0EntryLo0, lo1: cp0EntryLo1};

    excPriority uPrio (
        .wbExc     (wbExc),
        .statusIm  (statusIm),
        .statusIe  (statusIe),
        .statusExl (statusExl),
        .causeIp   (causeIp),
        .epc       (epc),
        .excKind   (excKind),
        .excTaken  (excTaken),
        .excTarget (excTarget)
    );

    cp0Regs uRegs (
        .clk           (clk),
        .arstN         (arstN),
        .extInt        (extInt),
        .cp0Wr         (cp0Wr),
        .cp0WrAddr     (cp0WrAddr),
        .cp0WrData     (cp0WrData),
        .cp0RdAddr     (cp0RdAddr),
        .tlbpReq       (tlbpReq),
        .tlbrReq       (tlbrReq),
        .excKind       (excKind),
        .wbPc          (wbPc),
        .wbInDelaySlot (wbInDelaySlot),
        .wbBadAddr     (wbBadAddr),
        .probeHit      (probeHit),
        .probeIdx      (probeIdx),
        .tlbRdEntry    (tlbRdEntry),
        .cp0RdData     (cp0RdData),
        .statusIm      (statusIm),
        .statusIe      (statusIe),
        .statusExl     (statusExl),
        .causeIp       (causeIp),
        .epc           (epc),
        .cp0Index      (cp0Index),
        .cp0EntryHi    (cp0EntryHi),
        .cp0EntryLo0   (cp0EntryLo0),
        .cp0EntryLo1   (cp0EntryLo1)
    );

    tlbArray uTlb (
        .clk      (clk),
        .arstN    (arstN),
        .tlbwiReq (tlbwiReq),
        .wrIdx    (cp0Index),
        .wrEntry  (wrEntry),
        .probeKey (cp0EntryHi),
        .rdIdx    (cp0Index),
        .probeHit (probeHit),
        .probeIdx (probeIdx),
        .rdEntry  (tlbRdEntry)
    );

endmodule

// ==== design/tlbArray.sv ====
// --------------------
// Joint TLB, TLB_ENTRIES entries, no page mask
// Multiple matches are not detected, the lowest index wins
// G is stored as the AND of both halves
// --------------------
`timescale 1ns/100ps
`include "cp0_params.svh"

module tlbArray import tlbPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  tlbwiReq,
    input  logic [`TLB_IDX_W-1:0] wrIdx,
    input  TlbEntry               wrEntry,
    input  EntryHiFields          probeKey,
    input  logic [`TLB_IDX_W-1:0] rdIdx,
    output logic                  probeHit,
    output logic [`TLB_IDX_W-1:0] probeIdx,
    output TlbEntry               rdEntry
);

    TlbEntry                entries [`TLB_ENTRIES];
    TlbEntry                wrStore;
    logic                   wrGlobal;
    logic [`TLB_ENTRIES-1:0] match;

    assign wrGlobal = wrEntry.lo0.g & wrEntry.lo1.g;

    always_comb begin
        wrStore       = wrEntry;
        wrStore.lo0.g = wrGlobal;
        wrStore.lo1.g = wrGlobal;
    end

    // Reset leaves every entry invalid
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (tlbwiReq) begin
            entries[wrIdx] <= wrStore;
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries[i].hi.vpn2 == probeKey.vpn2) &&
                       ((entries[i].hi.asid == probeKey.asid) ||
                        (entries[i].lo0.g && entries[i].lo1.g));
        end
    end

    // Scan downward so the lowest match is left last
    always_comb begin
        probeHit = 1'b0;
        probeIdx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                probeHit = 1'b1;
                probeIdx = `TLB_IDX_W'(i);
            end
        end
    end

    assign rdEntry = entries[rdIdx];

endmodule

// ==== list.f ====
+incdir+common
common/cp0Pkg.sv
common/tlbPkg.sv
cp0/excPriority.sv
cp0/cp0Regs.sv
design/tlbArray.sv
design/cp0Top.sv
verification/cp0_checker.sv
verification/cp0Tb.sv

// ==== verification/cp0Tb.sv ====
// --------------------
// cp0Top testbench, shadow model of every register
// Count is only checked right after it is written
// --------------------
`timescale 1ns/100ps
`include "cp0_params.svh"

module cp0Tb import cp0Pkg::*; ();

    localparam int TestCycles = 800;
    localparam int MarginCycles = 400;

    logic clk, arstN, cp0Wr, tlbpReq, tlbrReq, tlbwiReq, wbInDelaySlot;
    logic [5:0] extInt;
    logic [4:0] cp0WrAddr, cp0RdAddr;
    logic [31:0] cp0WrData, wbPc, wbBadAddr, cp0RdData, excTarget;
    logic excTaken;
    ExcFlags wbExc;

    integer seed = 32'hd618;
    logic chkEn;
    logic [31:0] expVal;

    // Shadow registers
    logic sP, sExl, sIe, sBd, sTi;
    logic [3:0] sIdx;
    logic [25:0] sLo0, sLo1;
    logic [18:0] sVpn;
    logic [7:0] sAsid, sIm;
    logic [31:0] sBadv, sCount, sCompare, sEpc;
    logic [5:0] sIp72;
    logic [1:0] sIp10;
    logic [4:0] sExc;
    logic [26:0] mHi [`TLB_ENTRIES];
    logic [25:0] mLo0 [`TLB_ENTRIES];
    logic [25:0] mLo1 [`TLB_ENTRIES];

    cp0Top UUT (.*);

    always #50 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] expectRead(input logic [4:0] addr);
        case (addr)
            `CP0_REG_INDEX:    return {sP, 27'b0, sIdx};
            `CP0_REG_ENTRYLO0: return {6'b0, sLo0};
            `CP0_REG_ENTRYLO1: return {6'b0, sLo1};
            `CP0_REG_BADVADDR: return sBadv;
            `CP0_REG_COUNT:    return sCount;
            `CP0_REG_ENTRYHI:  return {sVpn, 5'b0, sAsid};
            `CP0_REG_COMPARE:  return sCompare;
            `CP0_REG_STATUS:   return 32'h0040_0000 | {16'b0, sIm, 6'b0, sExl, sIe};
            `CP0_REG_CAUSE:    return {sBd, sTi, 14'b0, sIp72, sIp10, 1'b0, sExc, 2'b0};
            `CP0_REG_EPC:      return sEpc;
            default:           return 32'h0;
        endcase
    endfunction

    function automatic logic refIntReq();
        return (|({sIp72, sIp10} & sIm)) && sIe && !sExl;
    endfunction

    // Flag position of the winning exception, -1 for none
    function automatic int pickExc(input logic [12:0] f, input logic intReq);
        if (intReq) return 12;
        for (int i = 11; i >= 0; i--) begin
            if (f[i]) return i;
        end
        return -1;
    endfunction

    function automatic logic [4:0] codeFor(input int pos);
        case (pos)
            11, 3:   return 5'd4;
            10:      return 5'd10;
            9:       return 5'd8;
            8:       return 5'd9;
            6:       return 5'd13;
            5:       return 5'd12;
            4:       return 5'd5;
            2, 1:    return 5'd2;
            0:       return 5'd1;
            default: return 5'd0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (chkEn) begin
            checkValue("cp0RdData", cp0RdData, expVal);
        end
    end

    task automatic shadowWrite(input logic [4:0] addr, input logic [31:0] d);
        case (addr)
            `CP0_REG_INDEX:    sIdx = d[3:0];
            `CP0_REG_ENTRYLO0: sLo0 = d[25:0];
            `CP0_REG_ENTRYLO1: sLo1 = d[25:0];
            `CP0_REG_COUNT:    sCount = d;
            `CP0_REG_ENTRYHI:  {sVpn, sAsid} = {d[31:13], d[7:0]};
            `CP0_REG_COMPARE: begin
                sCompare = d;
                sTi = 1'b0;
            end
            `CP0_REG_STATUS:   {sIm, sExl, sIe} = {d[15:8], d[1], d[0]};
            `CP0_REG_CAUSE:    sIp10 = d[9:8];
            `CP0_REG_EPC:      sEpc = d;
            default: ;
        endcase
    endtask

    task automatic applyExc(input int pos, input logic [31:0] pc, input logic ds,
                            input logic [31:0] bad);
        if (pos == 7) begin
            sExl = 1'b0;
        end else if (pos >= 0) begin
            if (!sExl) begin
                sBd = ds;
                sEpc = ds ? pc - 32'd4 : pc;
            end
            sExl = 1'b1;
            sExc = codeFor(pos);
            if (pos == 11) sBadv = pc;
            else if (pos == 3 || pos == 4) sBadv = bad;
        end
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] d);
        @(negedge clk);
        cp0Wr = 1'b1;
        cp0WrAddr = addr;
        cp0WrData = d;
        @(negedge clk);
        cp0Wr = 1'b0;
        shadowWrite(addr, d);
    endtask

    task automatic readReg(input logic [4:0] addr);
        @(negedge clk);
        cp0RdAddr = addr;
        expVal = expectRead(addr);
        chkEn = 1'b1;
        @(negedge clk);
        chkEn = 1'b0;
    endtask

    task automatic presentExc(input logic [11:0] f, input logic [31:0] pc, input logic ds,
                              input logic [31:0] bad);
        int pos;
        @(negedge clk);
        wbExc = ExcFlags'({1'b0, f});
        wbPc = pc;
        wbInDelaySlot = ds;
        wbBadAddr = bad;
        pos = pickExc({1'b0, f}, refIntReq());
        #1;
        checkValue("excTaken", excTaken, (pos >= 0));
        if (pos == 7) checkValue("excTarget", excTarget, sEpc);
        else if (pos >= 0) checkValue("excTarget", excTarget, `EXC_VECTOR);
        @(negedge clk);
        wbExc = '0;
        applyExc(pos, pc, ds, bad);
    endtask

    // 0 writes, 1 probes, 2 reads the TLB
    task automatic pulseTlb(input int op);
        logic g;
        @(negedge clk);
        tlbwiReq = (op == 0);
        tlbpReq = (op == 1);
        tlbrReq = (op == 2);
        @(negedge clk);
        {tlbwiReq, tlbpReq, tlbrReq} = 3'b000;
        if (op == 0) begin
            g = sLo0[0] & sLo1[0];
            mHi[sIdx] = {sVpn, sAsid};
            mLo0[sIdx] = {sLo0[25:1], g};
            mLo1[sIdx] = {sLo1[25:1], g};
        end else if (op == 1) begin
            sP = 1'b1;
            sIdx = '0;
            for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
                if (mHi[i][26:8] == sVpn && (mHi[i][7:0] == sAsid || mLo0[i][0])) begin
                    sP = 1'b0;
                    sIdx = i[3:0];
                end
            end
        end else begin
            {sVpn, sAsid} = mHi[sIdx];
            sLo0 = mLo0[sIdx];
            sLo1 = mLo1[sIdx];
        end
    endtask

    initial begin
        #((TestCycles + MarginCycles) * 100);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] rnd;
        int pos;
        bit found;
        clk = 0;
        arstN = 0;
        {cp0Wr, tlbpReq, tlbrReq, tlbwiReq, wbInDelaySlot, chkEn} = '0;
        {extInt, cp0WrAddr, cp0RdAddr, cp0WrData, wbPc, wbBadAddr} = '0;
        wbExc = '0;
        {sP, sExl, sIe, sBd, sTi, sIdx, sLo0, sLo1, sVpn, sAsid, sIm} = '0;
        {sBadv, sCount, sEpc, sIp72, sIp10, sExc} = '0;
        sCompare = `COMPARE_RESET;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            {mHi[i], mLo0[i], mLo1[i]} = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1;

        // Write and readback, IE kept clear
        for (int a = 0; a < 32; a++) begin
            rnd = $random(seed);
            if (a == `CP0_REG_STATUS) rnd[0] = 1'b0;
            writeReg(a[4:0], rnd);
            readReg(a[4:0]);
        end
        writeReg(`CP0_REG_CAUSE, 0);
        writeReg(`CP0_REG_STATUS, 0);
        writeReg(`CP0_REG_COMPARE, `COMPARE_RESET);

        // Exception priority and capture
        for (int i = 0; i < 20; i++) begin
            if (i % 3 == 0) writeReg(`CP0_REG_STATUS, 0);
            rnd = $random(seed);
            presentExc(rnd[11:0], $random(seed), rnd[12], $random(seed));
            readReg(`CP0_REG_CAUSE);
            readReg(`CP0_REG_EPC);
            readReg(`CP0_REG_BADVADDR);
            readReg(`CP0_REG_STATUS);
        end

        // Eret
        writeReg(`CP0_REG_STATUS, 0);
        presentExc(12'h200, 32'h8000_0400, 1'b0, 0);
        presentExc(12'h080, 32'h8000_0500, 1'b0, 0);
        readReg(`CP0_REG_STATUS);

        // Timer interrupt on IP7
        writeReg(`CP0_REG_STATUS, 32'h0000_8001);
        wbPc = 32'h8000_1000;
        writeReg(`CP0_REG_COUNT, 32'd100);
        writeReg(`CP0_REG_COMPARE, 32'd110);
        found = 0;
        for (int w = 0; w < 60 && !found; w++) begin
            @(negedge clk);
            #1;
            if (excTaken) found = 1;
        end
        if (!found) begin
            $display("Timer interrupt did not arrive within the expected window");
            $display("Testbench failed");
            $fatal(1);
        end
        cp0RdAddr = `CP0_REG_CAUSE;
        #1;
        checkValue("Cause.TI", cp0RdData[30], 1'b1);
        checkValue("Cause.IP7", cp0RdData[15], 1'b1);
        checkValue("excTarget", excTarget, `EXC_VECTOR);
        applyExc(12, wbPc, 1'b0, 0);
        sTi = 1'b1;
        writeReg(`CP0_REG_STATUS, 0);
        sIp72 = '0;
        readReg(`CP0_REG_CAUSE);
        readReg(`CP0_REG_EPC);
        writeReg(`CP0_REG_COMPARE, `COMPARE_RESET);
        readReg(`CP0_REG_CAUSE);

        // External interrupts against mask, IE and EXL
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            @(negedge clk);
            extInt = rnd[5:0];
            wbPc = $random(seed);
            cp0Wr = 1'b1;
            cp0WrAddr = `CP0_REG_STATUS;
            cp0WrData = {16'b0, rnd[15:8], 6'b0, rnd[17], rnd[16]};
            @(negedge clk);
            shadowWrite(`CP0_REG_STATUS, cp0WrData);
            sIp72 = rnd[5:0];
            #1;
            checkValue("excTaken", excTaken, refIntReq());
            pos = refIntReq() ? 12 : -1;
            extInt = '0;
            cp0WrData = '0;
            @(negedge clk);
            applyExc(pos, wbPc, 1'b0, 0);
            sIm = '0;
            sIe = 1'b0;
            if (pos < 0) sExl = 1'b0;
            sIp72 = '0;
            @(negedge clk);
            cp0Wr = 1'b0;
            sExl = 1'b0;
            readReg(`CP0_REG_CAUSE);
            readReg(`CP0_REG_EPC);
        end

        // TLB write, probe and read
        for (int k = 5; k < 16; k += 4) begin
            writeReg(`CP0_REG_ENTRYHI, $random(seed));
            // One G bit on entry 5 and both on entry 13
            rnd = $random(seed);
            writeReg(`CP0_REG_ENTRYLO0, rnd | (k != 9));
            rnd = $random(seed);
            rnd[0] = (k == 13);
            writeReg(`CP0_REG_ENTRYLO1, rnd);
            writeReg(`CP0_REG_INDEX, k);
            pulseTlb(0);
        end
        writeReg(`CP0_REG_ENTRYHI, {mHi[9][26:8], 5'b0, mHi[9][7:0]});
        pulseTlb(1);
        readReg(`CP0_REG_INDEX);
        writeReg(`CP0_REG_ENTRYHI, $random(seed));
        pulseTlb(1);
        readReg(`CP0_REG_INDEX);
        for (int k = 13; k > 0; k -= 8) begin
            writeReg(`CP0_REG_INDEX, k);
            pulseTlb(2);
            readReg(`CP0_REG_ENTRYHI);
            readReg(`CP0_REG_ENTRYLO0);
            readReg(`CP0_REG_ENTRYLO1);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verification/cp0_checker.sv ====
// --------------------
// Assertions bound into cp0Top
// Count check ignores wrap-around
// --------------------
`timescale 1ns/100ps
`include "cp0_params.svh"

module cp0_checker import cp0Pkg::*; (
    input logic        clk,
    input logic        arstN,
    input logic        excTaken,
    input logic [31:0] excTarget,
    input ExcFlags     wbExc,
    input logic        cp0Wr,
    input logic [4:0]  cp0WrAddr,
    input logic [4:0]  cp0RdAddr,
    input logic [31:0] cp0RdData
);

    logic countWr;

    assign countWr = cp0Wr && (cp0WrAddr == `CP0_REG_COUNT);

    resetQuiet: assert property (@(posedge clk) !arstN |-> !excTaken)
        else $error("excTaken high during reset");

    vectorTarget: assert property (@(posedge clk) disable iff (!arstN)
        (excTaken && !wbExc.eret) |-> (excTarget == `EXC_VECTOR))
        else $error("excTarget is not the exception vector");

    // Two consecutive Count reads with no write in between
    countMonotonic: assert property (@(posedge clk) disable iff (!arstN)
        ((cp0RdAddr == `CP0_REG_COUNT) && ($past(cp0RdAddr) == `CP0_REG_COUNT) &&
         !$past(countWr)) |-> (cp0RdData >= $past(cp0RdData)))
        else $error("Count readback decreased");

endmodule

bind cp0Top cp0_checker uChk (
    .clk       (clk),
    .arstN     (arstN),
    .excTaken  (excTaken),
    .excTarget (excTarget),
    .wbExc     (wbExc),
    .cp0Wr     (cp0Wr),
    .cp0WrAddr (cp0WrAddr),
    .cp0RdAddr (cp0RdAddr),
    .cp0RdData (cp0RdData)
);
